/* rtl/icache_pkg.sv */
package icache_pkg;

  // byte address of the fetch stage
  localparam int addr_bits = 32;

  // 16-byte blocks, so the low four address bits pick a byte in the block
  localparam int offset_bits = 4;

  localparam int block_bytes = 1 << offset_bits;

  localparam int block_bits = 8 * block_bytes;  // one refill beat carries a whole block

  localparam int instr_bits = 32;

  localparam int instr_bytes = instr_bits / 8;

  // highest offset at which all four instruction bytes sit in the same block
  // anything above this spills into the following block
  localparam int last_aligned_offset = block_bytes - instr_bytes;

endpackage

/* rtl/icache_fsm.sv */
`timescale 1ns/1ps

module icache_fsm (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               hit,                // pc block is present
  input  logic                               hit_missalign,      // following block is present
  input  logic                               mem_ready,          // one-cycle pulse, block is on the bus
  input  logic [icache_pkg::offset_bits-1:0] block_offset,       // byte offset of pc in its block
  output logic                               cache_rden,         // arrays are being read for the fetch
  output logic                               cache_wren,         // write the incoming block
  output logic                               mem_rden,           // block request, level until mem_ready
  output logic                               set_valid,
  output logic                               replace_tag,
  output logic                               stall,              // holds pc and the pipeline
  output logic                               addr_sel,           // 0 pc block, 1 following block
  output logic                               set_valid_align,
  output logic                               replace_tag_align
);
  import icache_pkg::*;

  typedef enum logic [1:0] {
    normal_op,
    allocate_1,
    allocate_2,
    cache_access
  } state_t;

  state_t state;
  state_t next_state;
  logic   crossing;

  // the instruction needs bytes from the next block as well
  assign crossing = (block_offset > last_aligned_offset);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= normal_op;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state        = state;
    cache_rden        = 1'b0;
    cache_wren        = 1'b0;
    mem_rden          = 1'b0;
    set_valid         = 1'b0;
    replace_tag       = 1'b0;
    stall             = 1'b0;
    addr_sel          = 1'b0;
    set_valid_align   = 1'b0;
    replace_tag_align = 1'b0;

    case (state)
      normal_op: begin
        if (!hit) begin
          next_state = allocate_1;  // pc block first, the following block is checked after it
          mem_rden   = 1'b1;
          stall      = 1'b1;
        end else if (crossing && !hit_missalign) begin
          next_state = allocate_2;
          mem_rden   = 1'b1;
          addr_sel   = 1'b1;
          stall      = 1'b1;
        end else begin
          cache_rden = 1'b1;  // plain hit, instr goes out this cycle
          set_valid  = 1'b1;  // valid is already set here so this rewrite changes nothing
        end
      end

      allocate_1: begin
        stall = 1'b1;
        if (mem_ready) begin
          cache_wren  = 1'b1;
          set_valid   = 1'b1;
          replace_tag = 1'b1;
          if (crossing && !hit_missalign) begin
            next_state = allocate_2;  // second refill follows without a gap
          end else begin
            next_state = cache_access;
          end
        end else begin
          mem_rden = 1'b1;
        end
      end

      allocate_2: begin
        stall    = 1'b1;
        addr_sel = 1'b1;  // memory address and write index point at the following block
        if (mem_ready) begin
          cache_wren        = 1'b1;
          set_valid_align   = 1'b1;
          replace_tag_align = 1'b1;
          next_state        = cache_access;
        end else begin
          mem_rden = 1'b1;
        end
      end

      cache_access: begin
        // both blocks are written by now, so instr is good with stall low
        cache_rden = 1'b1;
        next_state = normal_op;
      end

      default: begin
        next_state = normal_op;
      end
    endcase
  end

  // the memory request must not be withdrawn while memory is still working on it
  a_rden_held: assert property (
    @(posedge clk) disable iff (rst)
      (mem_rden && !mem_ready) |=> (mem_rden || mem_ready)
  ) else $error("mem_rden dropped before mem_ready");

  a_wren_with_ready: assert property (
    @(posedge clk) disable iff (rst)
      cache_wren |-> mem_ready
  ) else $error("cache_wren without a block from memory");

  a_access_no_stall: assert property (
    @(posedge clk) disable iff (rst)
      (state == cache_access) |-> !stall
  ) else $error("stall high in cache_access");

endmodule

/* rtl/icache_tag_store.sv */
`timescale 1ns/1ps

module icache_tag_store #(
  parameter int index_bits = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [icache_pkg::addr_bits-1:0] pc,
  input  logic                             set_valid,
  input  logic                             replace_tag,
  input  logic                             set_valid_align,
  input  logic                             replace_tag_align,
  input  logic                             addr_sel,           // 0 pc block, 1 following block
  output logic                             hit,
  output logic                             hit_missalign,
  output logic [icache_pkg::addr_bits-1:0] mem_addr
);
  import icache_pkg::*;

  localparam int num_sets       = 1 << index_bits;
  localparam int block_num_bits = addr_bits - offset_bits;
  localparam int tag_bits       = block_num_bits - index_bits;

  logic [tag_bits-1:0]       tags [num_sets];
  logic [num_sets-1:0]       valid;
  logic [block_num_bits-1:0] pc_block;
  logic [block_num_bits-1:0] next_block;
  logic [block_num_bits-1:0] sel_block;
  logic [index_bits-1:0]     pc_index;
  logic [index_bits-1:0]     next_index;
  logic [index_bits-1:0]     wr_index;
  logic [tag_bits-1:0]       pc_tag;
  logic [tag_bits-1:0]       next_tag;
  logic [tag_bits-1:0]       wr_tag;

  assign pc_block   = pc[addr_bits-1:offset_bits];
  assign next_block = pc_block + 1'b1;  // a wrap out of the last set carries into the tag

  assign pc_index   = pc_block[index_bits-1:0];
  assign pc_tag     = pc_block[block_num_bits-1:index_bits];
  assign next_index = next_block[index_bits-1:0];
  assign next_tag   = next_block[block_num_bits-1:index_bits];

  assign hit           = valid[pc_index] && (tags[pc_index] == pc_tag);
  assign hit_missalign = valid[next_index] && (tags[next_index] == next_tag);

  // the same select drives the refill address and the tag write
  assign sel_block = addr_sel ? next_block : pc_block;
  assign wr_index  = sel_block[index_bits-1:0];
  assign wr_tag    = sel_block[block_num_bits-1:index_bits];
  assign mem_addr  = {sel_block, {offset_bits{1'b0}}};

  always_ff @(posedge clk) begin
    if (replace_tag || replace_tag_align) begin
      tags[wr_index] <= wr_tag;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid <= '0;
    end else if (set_valid || set_valid_align) begin
      valid[wr_index] <= 1'b1;
    end
  end

  a_one_tag_write: assert property (
    @(posedge clk) disable iff (rst)
      !(replace_tag && replace_tag_align)
  ) else $error("both tag writes in one cycle");

  // a following-block tag written at the pc index would corrupt the set
  a_align_sel: assert property (
    @(posedge clk) disable iff (rst)
      replace_tag_align |-> addr_sel
  ) else $error("replace_tag_align with addr_sel low");

endmodule

/* rtl/icache_data_array.sv */
`timescale 1ns/1ps

module icache_data_array #(
  parameter int index_bits = 4
) (
  input  logic                              clk,
  input  logic [icache_pkg::addr_bits-1:0]  pc,
  input  logic                              cache_wren,
  input  logic                              addr_sel,    // 0 pc set, 1 following set
  input  logic [icache_pkg::block_bits-1:0] mem_rdata,   // byte k of the block in bits 8k+7:8k
  output logic [icache_pkg::instr_bits-1:0] instr
);
  import icache_pkg::*;

  localparam int num_sets = 1 << index_bits;

  logic [block_bits-1:0]   blocks [num_sets];
  logic [offset_bits-1:0]  pc_offset;
  logic [index_bits-1:0]   pc_index;
  logic [index_bits-1:0]   next_index;
  logic [index_bits-1:0]   wr_index;
  logic [2*block_bits-1:0] pair;
  logic [offset_bits+2:0]  bit_pos;

  assign pc_offset  = pc[offset_bits-1:0];
  assign pc_index   = pc[offset_bits +: index_bits];
  assign next_index = pc_index + 1'b1;  // wraps to set 0 from the last set

  assign wr_index = addr_sel ? next_index : pc_index;

  always_ff @(posedge clk) begin
    if (cache_wren) begin
      blocks[wr_index] <= mem_rdata;
    end
  end

  // following block sits above the pc block, so a crossing word just runs on upward
  assign pair    = {blocks[next_index], blocks[pc_index]};
  assign bit_pos = {pc_offset, 3'b000};
  assign instr   = pair[bit_pos +: instr_bits];  // little endian, lowest byte at pc

endmodule

/* rtl/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
  parameter int index_bits = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [icache_pkg::addr_bits-1:0]  pc,          // held by the fetch stage while stall
  output logic [icache_pkg::instr_bits-1:0] instr,       // good in any cycle with stall low
  output logic                              stall,
  output logic                              mem_rden,
  output logic [icache_pkg::addr_bits-1:0]  mem_addr,    // block aligned
  input  logic                              mem_ready,
  input  logic [icache_pkg::block_bits-1:0] mem_rdata
);
  import icache_pkg::*;

  logic hit;
  logic hit_missalign;
  logic cache_rden;         // read strobe kept from the controller, nothing outside needs it
  logic cache_wren;
  logic set_valid;
  logic replace_tag;
  logic set_valid_align;
  logic replace_tag_align;
  logic addr_sel;

  icache_fsm i_icache_fsm (
    .clk               (clk),
    .rst               (rst),
    .hit               (hit),
    .hit_missalign     (hit_missalign),
    .mem_ready         (mem_ready),
    .block_offset      (pc[offset_bits-1:0]),
    .cache_rden        (cache_rden),
    .cache_wren        (cache_wren),
    .mem_rden          (mem_rden),
    .set_valid         (set_valid),
    .replace_tag       (replace_tag),
    .stall             (stall),
    .addr_sel          (addr_sel),
    .set_valid_align   (set_valid_align),
    .replace_tag_align (replace_tag_align)
  );

  icache_tag_store #(
    .index_bits (index_bits)
  ) i_icache_tag_store (
    .clk               (clk),
    .rst               (rst),
    .pc                (pc),
    .set_valid         (set_valid),
    .replace_tag       (replace_tag),
    .set_valid_align   (set_valid_align),
    .replace_tag_align (replace_tag_align),
    .addr_sel          (addr_sel),
    .hit               (hit),
    .hit_missalign     (hit_missalign),
    .mem_addr          (mem_addr)
  );

  icache_data_array #(
    .index_bits (index_bits)
  ) i_icache_data_array (
    .clk        (clk),
    .pc         (pc),
    .cache_wren (cache_wren),
    .addr_sel   (addr_sel),
    .mem_rdata  (mem_rdata),
    .instr      (instr)
  );

endmodule

/* sim/mem_model.sv */
`timescale 1ns/1ps

module mem_model #(
  parameter logic [31:0] seed     = 32'haf57,
  parameter logic [7:0]  byte_key = 8'h3c
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              mem_rden,
  input  logic [icache_pkg::addr_bits-1:0]  mem_addr,
  output logic                              mem_ready,
  output logic [icache_pkg::block_bits-1:0] mem_rdata,
  output logic                              request_error  // sticky, set on a bad request
);
  import icache_pkg::*;

  logic [31:0]          rng;
  logic [addr_bits-1:0] req_addr;
  int                   latency;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // the byte at address a is its low byte xor the next byte xor the key
  function automatic logic [7:0] rule_byte(input logic [addr_bits-1:0] a);
    return a[7:0] ^ a[15:8] ^ byte_key;
  endfunction

  function automatic logic [block_bits-1:0] build_block(input logic [addr_bits-1:0] base);
    logic [block_bits-1:0] blk;
    blk = '0;
    for (int k = 0; k < block_bytes; k++) begin
      blk[8*k +: 8] = rule_byte(base + addr_bits'(k));  // byte k in bits 8k+7:8k
    end
    return blk;
  endfunction

  initial begin
    mem_ready     = 1'b0;
    mem_rdata     = '0;
    request_error = 1'b0;
    rng           = seed;
    forever begin
      @(posedge clk);
      if (!rst && mem_rden) begin
        req_addr = mem_addr;
        if (req_addr[offset_bits-1:0] != '0) begin
          request_error = 1'b1;  // refill address must be block aligned
          $display("time %0t: memory request at %h is not block aligned", $time, req_addr);
        end
        rng     = xorshift(rng);
        latency = 1 + int'(rng[1:0]);  // 1 to 4 cycles
        for (int w = 1; w < latency; w++) begin
          @(posedge clk);
          if (!mem_rden || mem_addr != req_addr) begin
            request_error = 1'b1;  // request withdrawn or moved while pending
            $display("time %0t: memory request for %h was dropped or moved while pending",
                     $time, req_addr);
          end
        end
        #1;
        mem_rdata = build_block(req_addr);
        mem_ready = 1'b1;
        @(posedge clk);
        #1;
        mem_ready = 1'b0;  // one-cycle pulse
      end
    end
  end

endmodule

/* sim/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;
  import icache_pkg::*;

  localparam int index_bits       = 4;
  localparam int max_fetches      = 64;
  localparam int reset_cycles     = 10;
  localparam int cycles_per_fetch = 30;

  logic                  clk = 1'b0;
  logic                  rst;
  logic [addr_bits-1:0]  pc;
  logic [instr_bits-1:0] instr;
  logic                  stall;
  logic                  mem_rden;
  logic [addr_bits-1:0]  mem_addr;
  logic                  mem_ready;
  logic [block_bits-1:0] mem_rdata;
  logic                  request_error;

  logic [31:0] patterns [3*max_fetches];  // pc, instruction, refill count per fetch
  int          fetch_count;
  int          pass_count;
  int          fail_count;
  int          refills_total = 0;
  int          cycle_count = 0;
  int          cycle_limit;

  always #50 clk = ~clk;

  icache_top #(
    .index_bits (index_bits)
  ) i_icache_top (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .instr     (instr),
    .stall     (stall),
    .mem_rden  (mem_rden),
    .mem_addr  (mem_addr),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

  mem_model #(
    .seed     (32'haf57),
    .byte_key (8'h3c)
  ) i_mem_model (
    .clk           (clk),
    .rst           (rst),
    .mem_rden      (mem_rden),
    .mem_addr      (mem_addr),
    .mem_ready     (mem_ready),
    .mem_rdata     (mem_rdata),
    .request_error (request_error)
  );

  always @(posedge clk) begin
    if (mem_ready) begin
      refills_total <= refills_total + 1;  // every pulse is one block written
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the cache stalled too long, no result within %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  task automatic fetch_and_check(input int idx);
    logic [addr_bits-1:0]  fetch_pc;
    logic [instr_bits-1:0] expected_instr;
    int                    expected_refills;
    int                    refills_start;
    int                    refills_seen;
    int                    cycles;
    int                    last_ready_cycle;
    bit                    ok;
    fetch_pc         = patterns[3*idx];
    expected_instr   = patterns[3*idx+1];
    expected_refills = int'(patterns[3*idx+2]);
    ok               = 1'b1;
    pc               = fetch_pc;  // held until stall is seen low
    refills_start    = refills_total;
    cycles           = 0;
    last_ready_cycle = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (mem_ready) begin
        last_ready_cycle = cycles;  // the refill lands at this edge
      end
    end while (stall);
    refills_seen = refills_total - refills_start;
    if (instr !== expected_instr) begin
      $display("[FAIL] time %0t fetch %0d pc %h: instr %h, expected %h",
               $time, idx, fetch_pc, instr, expected_instr);
      ok = 1'b0;
    end
    if (refills_seen != expected_refills) begin
      $display("[FAIL] time %0t fetch %0d pc %h: %0d refills, expected %0d",
               $time, idx, fetch_pc, refills_seen, expected_refills);
      ok = 1'b0;
    end
    // a hit ends in its first cycle, a refill is followed by one cache_access cycle
    if (cycles != last_ready_cycle + 1) begin
      $display("[FAIL] time %0t fetch %0d pc %h: stall fell after %0d cycles, expected %0d",
               $time, idx, fetch_pc, cycles, last_ready_cycle + 1);
      ok = 1'b0;
    end
    if (ok) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("fetch %0d pc %h: %0d refills, %s", idx, fetch_pc, refills_seen,
             ok ? "ok" : "wrong");
  endtask

  initial begin
    rst        = 1'b1;
    pc         = '0;
    pass_count = 0;
    fail_count = 0;
    for (int i = 0; i < 3*max_fetches; i++) begin
      patterns[i] = '1;  // an all-ones refill count marks the end of the data
    end
    $readmemh("sim/fetch_patterns.txt", patterns);
    fetch_count = 0;
    while (fetch_count < max_fetches && patterns[3*fetch_count+2] != '1) begin
      fetch_count++;
    end
    cycle_limit = fetch_count * cycles_per_fetch + reset_cycles;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < fetch_count; i++) begin
      fetch_and_check(i);
      #1;
    end
    if (fetch_count == 0) begin
      $display("no fetch patterns were read from the data file");
    end
    if (request_error) begin
      $display("the memory model saw a request that was unaligned or changed while pending");
    end
    $display("fetches %0d, passed %0d, failed %0d", fetch_count, pass_count, fail_count);
    if (fetch_count > 0 && fail_count == 0 && !request_error) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* sim/fetch_patterns.txt */
// columns: pc, expected instruction (little endian), expected refill count
// all values hex, one fetch per line, run in order against one cache
// cold miss at an aligned offset
00001000 2f2e2d2c 1
// same block, offsets up to 12
00001004 2b2a2928 0
00001008 27262524 0
0000100c 23222120 0
00001002 29282f2e 0
// crossing fetches: both absent, next absent, pc block absent, both present
0000101d 0c333231 2
0000102f 1e1d1c03 1
00001050 7f7e7d7c 1
0000104e 7d7c6362 1
0000101e 0d0c3332 0
0000104d 7c636261 0
// conflicts in sets 0, 1 and 2
00002000 1f1e1d1c 1
00001004 2b2a2928 1
00002008 17161514 1
0000201d 3c030201 2
0000101d 0c333231 2
// index wrap from set 15 into set 0 under the next tag
000010fd 2dd3d2d1 2
000010ff 2f2c2dd3 0
00001100 2e2f2c2d 0
// wide tag in set 3, then a crossing fetch that needs set 3 back
abcd1234 19181b1a 1
0000102f 1e1d1c03 1

/* filelist.f */
rtl/icache_pkg.sv
rtl/icache_fsm.sv
rtl/icache_tag_store.sv
rtl/icache_data_array.sv
rtl/icache_top.sv
sim/mem_model.sv
sim/icache_tb.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = icache_tb
RTL_TOP    = icache_top
FILELIST   = filelist.f
PASS_MSG   = test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
